//--- rtl/rc_servo_pkg.sv
// rc servo package: shared widths, register map, config bits and FSM state encodings

package rc_servo_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // data types
   ////////////////////////////////////////////////////////////////////////////

   // one bus word, also the width of every register
   typedef logic [31:0] word_t;

   // register address as seen on the bus
   typedef logic [7:0] addr_t;

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////

   // number of servo outputs, one on-time register each
   localparam int nos_channels = 4;

   // first address of the servo register window
   localparam addr_t rc_base = 8'h20;

   // word offsets inside the window
   localparam addr_t rc_period_ofs  = 8'd0;
   localparam addr_t rc_config_ofs  = 8'd1;
   localparam addr_t rc_status_ofs  = 8'd2;
   localparam addr_t rc_on_time_ofs = 8'd3;

   // window size in words, on-time registers are last
   localparam addr_t rc_window_words = rc_on_time_ofs + addr_t'(nos_channels);

   // config bit 31 runs the frame counter, bits 0..nos_channels-1 enable channels
   localparam int rc_global_enable_bit = 31;

   ////////////////////////////////////////////////////////////////////////////
   // state machines
   ////////////////////////////////////////////////////////////////////////////

   // bus handshake FSM
   typedef enum logic [1:0] {bus_idle, bus_strobe, bus_ack} bus_state_t;

   // per-channel pulse FSM
   typedef enum logic [1:0] {ch_idle, ch_load, ch_on} chan_state_t;

endpackage

//--- rtl/bus_fsm.sv
// bus handshake FSM: turns one host transaction into a single read or write strobe and an ack
`timescale 1ns/10ps

module bus_fsm (
   input  logic clk,
   input  logic reset,
   input  logic select,
   input  logic handshake_1,
   input  logic rw,
   output logic write_strobe,
   output logic read_strobe,
   output logic handshake_2
);

   import rc_servo_pkg::*;

   bus_state_t state;
   bus_state_t next_state;

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      case (state)
         // host request for our window starts a transaction
         bus_idle: begin
            if (handshake_1 && select) begin
               next_state = bus_strobe;
            end
         end
         // strobe state lasts a single cycle
         bus_strobe: begin
            next_state = bus_ack;
         end
         // wait here until the host lets go of handshake_1
         bus_ack: begin
            if (!handshake_1) begin
               next_state = bus_idle;
            end
         end
         default: begin
            next_state = bus_idle;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // state and registered outputs
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state        <= bus_idle;
         write_strobe <= 1'b0;
         read_strobe  <= 1'b0;
         handshake_2  <= 1'b0;
      end else begin
         state <= next_state;
         // rw picks which strobe fires, high for the cycle after bus_strobe
         write_strobe <= (state == bus_strobe) && rw;
         read_strobe  <= (state == bus_strobe) && !rw;
         // ack rises one cycle after the strobe, so the register/readback is settled
         // drops on the edge that sees handshake_1 low
         handshake_2  <= (state == bus_ack) && handshake_1;
      end
   end

endmodule

//--- rtl/rc_servo_channel.sv
// servo channel: one pulse per frame, high for the programmed number of clock cycles
`timescale 1ns/10ps

module rc_servo_channel (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,
   input  logic                  frame_start,
   input  rc_servo_pkg::word_t   on_time,
   output logic                  servo
);

   import rc_servo_pkg::*;

   chan_state_t state;

   // cycles of high time still to go
   word_t on_count;

   ////////////////////////////////////////////////////////////////////////////
   // channel FSM
   //
   // frame_start seen in ch_idle at edge F
   //   F+1  ch_load takes on_time into the counter
   //   F+2  first ch_on edge, servo rises unless on_time is zero
   // the last high edge already returns to ch_idle, which then clears servo,
   // so the channel is back in ch_idle early enough for on_time = period-1
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state    <= ch_idle;
         on_count <= '0;
         servo    <= 1'b0;
      end else begin
         case (state)
            ch_idle: begin
               // output low between pulses
               servo <= 1'b0;
               // enable only looked at here, so a change waits for the next frame
               if (frame_start && enable) begin
                  state <= ch_load;
               end
            end

            ch_load: begin
               // snapshot of on_time, later writes only hit the next frame
               on_count <= on_time;
               state    <= ch_on;
            end

            ch_on: begin
               // high while counts remain, zero on_time gives no pulse at all
               servo <= (on_count != '0);
               if (on_count != '0) begin
                  on_count <= on_count - 1'b1;
               end
               // final high cycle or empty pulse, back to idle
               // frame_start arriving in this state is not seen
               if (on_count <= word_t'(1)) begin
                  state <= ch_idle;
               end
            end

            default: begin
               state <= ch_idle;
               servo <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- rtl/rc_servo.sv
// rc servo top level with the register window on the host bus, frame period counter and channels
`timescale 1ns/10ps

module rc_servo (
   input  logic                                 clk,
   input  logic                                 reset,
   input  rc_servo_pkg::addr_t                  reg_address,
   input  logic                                 rw,
   input  rc_servo_pkg::word_t                  data_out,
   input  logic                                 handshake_1,
   output rc_servo_pkg::word_t                  data_in,
   output logic                                 handshake_2,
   output logic [rc_servo_pkg::nos_channels-1:0] servo
);

   import rc_servo_pkg::*;

   // bus side
   logic  select;
   logic  write_strobe;
   logic  read_strobe;
   addr_t reg_offset;
   word_t read_data;
   word_t data_in_reg;

   // host visible registers
   word_t period_reg;
   word_t config_reg;
   word_t status_word;
   word_t on_time_reg [nos_channels];

   // frame timing
   word_t period_count;
   logic  global_enable;
   logic  frame_start;

   ////////////////////////////////////////////////////////////////////////////
   // bus interface
   ////////////////////////////////////////////////////////////////////////////

   // window is rc_base up to, not including, rc_base + rc_window_words
   always_comb begin
      select = (reg_address >= rc_base) && (reg_address < (rc_base + rc_window_words));
   end

   // word offset inside the window
   // addresses below rc_base wrap to large values
   assign reg_offset = reg_address - rc_base;

   bus_fsm u_bus_fsm (
      .clk          (clk),
      .reset        (reset),
      .select       (select),
      .handshake_1  (handshake_1),
      .rw           (rw),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe),
      .handshake_2  (handshake_2)
   );

   // register file
   // status is read only so writes to it fall through
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_reg <= '0;
         config_reg <= '0;
         for (int i = 0; i < nos_channels; i++) begin
            on_time_reg[i] <= '0;
         end
      end else if (write_strobe) begin
         if (reg_offset == rc_period_ofs) begin
            period_reg <= data_out;
         end
         if (reg_offset == rc_config_ofs) begin
            config_reg <= data_out;
         end
         for (int i = 0; i < nos_channels; i++) begin
            if (reg_offset == addr_t'(rc_on_time_ofs + i)) begin
               on_time_reg[i] <= data_out;
            end
         end
      end
   end

   // live outputs in the low bits and global enable on top
   always_comb begin
      status_word = '0;
      status_word[nos_channels-1:0] = servo;
      status_word[rc_global_enable_bit] = global_enable;
   end

   // readback mux
   always_comb begin
      read_data = '0;
      case (reg_offset)
         rc_period_ofs: read_data = period_reg;
         rc_config_ofs: read_data = config_reg;
         rc_status_ofs: read_data = status_word;
         default:       read_data = '0;
      endcase
      for (int i = 0; i < nos_channels; i++) begin
         if (reg_offset == addr_t'(rc_on_time_ofs + i)) begin
            read_data = on_time_reg[i];
         end
      end
   end

   // loaded with the strobe and held until the host drops handshake_1
   // cleared on the same edge that drops the ack
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         data_in_reg <= '0;
      end else if (read_strobe) begin
         data_in_reg <= read_data;
      end else if (write_strobe) begin
         // write completes with the status word on the bus
         data_in_reg <= status_word;
      end else if (!handshake_1) begin
         data_in_reg <= '0;
      end
   end

   // single subsystem on the bus so it drives low when not addressed
   assign data_in = select ? data_in_reg : '0;

   ////////////////////////////////////////////////////////////////////////////
   // frame period counter
   ////////////////////////////////////////////////////////////////////////////

   assign global_enable = config_reg[rc_global_enable_bit];

   // down from period to zero then reload for period+1 cycles per frame
   // held where it is while global enable is clear
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_count <= '0;
      end else if (global_enable) begin
         if (period_count == '0) begin
            period_count <= period_reg;
         end else begin
            period_count <= period_count - 1'b1;
         end
      end
   end

   // one cycle at zero and gated so a frozen counter does not keep firing
   assign frame_start = global_enable && (period_count == '0);

   ////////////////////////////////////////////////////////////////////////////
   // servo channels
   ////////////////////////////////////////////////////////////////////////////

   for (genvar ch = 0; ch < nos_channels; ch++) begin : g_channel
      rc_servo_channel u_channel (
         .clk         (clk),
         .reset       (reset),
         .enable      (config_reg[ch]),
         .frame_start (frame_start),
         .on_time     (on_time_reg[ch]),
         .servo       (servo[ch])
      );
   end

endmodule

//--- tests/tb_clock.sv
// testbench clock and reset source, 20 ns clock with active-low reset held for 5 cycles
`timescale 1ns/10ps

module tb_clock (
   output logic clk,
   output logic reset
);

   localparam int half_period  = 10;
   localparam int reset_cycles = 5;

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // release lands off the edge, same offset as the stimulus
   initial begin
      reset = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      reset = 1'b1;
   end

endmodule

//--- tests/tb_rc_servo.sv
// rc servo testbench with bus access, a pulse monitor against a reference model and register checks
`timescale 1ns/10ps

module tb_rc_servo;

   import rc_servo_pkg::*;

   localparam int hs_timeout = 20;

   logic clk;
   logic reset;
   addr_t reg_address;
   logic rw;
   word_t data_out;
   logic handshake_1;
   word_t data_in;
   logic handshake_2;
   logic [nos_channels-1:0] servo;

   // reference model state for what the registers should hold
   word_t model_period;
   word_t model_config;
   word_t model_on [nos_channels];
   word_t rng_state = 32'hbc07;
   word_t rd;

   // monitor state with widths and last rise in negedge cycles
   // -1 marks an unknown value
   logic monitor_on;
   int cyc;
   int width [nos_channels];
   int last_rise [nos_channels];
   int rise_count [nos_channels];
   logic [nos_channels-1:0] prev_servo;
   logic [nos_channels-1:0] servo_seen;
   logic [nos_channels-1:0] servo_at_ack;
   logic [32:0] pulse_ref;

   tb_clock u_clock (.clk(clk), .reset(reset));

   rc_servo u_dut (
      .clk         (clk),
      .reset       (reset),
      .reg_address (reg_address),
      .rw          (rw),
      .data_out    (data_out),
      .handshake_1 (handshake_1),
      .data_in     (data_in),
      .handshake_2 (handshake_2),
      .servo       (servo)
   );

   ////////////////////////////////////////////////////////////////////////////
   // reference, random source and checking
   ////////////////////////////////////////////////////////////////////////////

   // bit 32 says a pulse occurs and the low bits give its width in cycles
   function automatic logic [32:0] expected_pulse(input word_t cfg, input word_t on_time,
                                                  input int ch);
      if (cfg[rc_global_enable_bit] && cfg[ch] && (on_time != '0)) begin
         return {1'b1, on_time};
      end
      return {1'b0, 32'd0};
   endfunction

   function automatic word_t xorshift(input word_t s);
      word_t x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
         fail_run("value check failed");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // bus tasks with all stimulus changes 2 ns after the rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic bus_transfer(input addr_t addr, input logic write, input word_t wdata,
                               output word_t rdata);
      int waited;
      reg_address = addr;
      rw          = write;
      data_out    = wdata;
      handshake_1 = 1'b1;
      waited      = 0;
      // ack two edges after the request is seen
      do begin
         wait_cycles(1);
         waited++;
         if (waited > hs_timeout) begin
            fail_run($sformatf("no handshake_2 for address %h at %0t", addr, $time));
         end
      end while (!handshake_2);
      rdata = data_in;
      // status took the outputs seen on the negedge before this ack edge
      servo_at_ack = servo_seen;
      handshake_1  = 1'b0;
      waited       = 0;
      while (handshake_2) begin
         wait_cycles(1);
         waited++;
         if (waited > hs_timeout) begin
            fail_run($sformatf("handshake_2 stuck high at %0t", $time));
         end
      end
      // bus returns to zero once the ack is gone
      check_value("data_in", data_in, '0);
   endtask

   // a write completes with the status word as it stood before the write
   task automatic bus_write(input addr_t addr, input word_t wdata);
      word_t ack_word;
      word_t exp_status;
      bus_transfer(addr, 1'b1, wdata, ack_word);
      exp_status = '0;
      exp_status[nos_channels-1:0] = servo_at_ack;
      exp_status[rc_global_enable_bit] = model_config[rc_global_enable_bit];
      check_value("data_in", ack_word, exp_status);
   endtask

   task automatic bus_read(input addr_t addr, output word_t rdata);
      bus_transfer(addr, 1'b0, '0, rdata);
   endtask

   task automatic read_expect(input addr_t ofs, input word_t exp, input string name);
      word_t value;
      bus_read(rc_base + ofs, value);
      check_value(name, value, exp);
   endtask

   // new config and then two frames before the monitor judges pulses
   task automatic apply_config(input word_t cfg);
      monitor_on = 1'b0;
      bus_write(rc_base + rc_config_ofs, cfg);
      model_config = cfg;
      wait_cycles(2 * (model_period + 1));
      monitor_on = 1'b1;
   endtask

   // a channel counts as pulsing when it rose at least three times
   task automatic check_pulse_counts();
      for (int ch = 0; ch < nos_channels; ch++) begin
         pulse_ref = expected_pulse(model_config, model_on[ch], ch);
         check_value($sformatf("servo[%0d] pulsing", ch), rise_count[ch] >= 3, pulse_ref[32]);
      end
   endtask

   // the missing ack is the expected outcome for an unmapped address
   task automatic probe_unmapped(input addr_t addr);
      reg_address = addr;
      rw          = 1'b0;
      handshake_1 = 1'b1;
      for (int waited = 0; waited < hs_timeout; waited++) begin
         wait_cycles(1);
         check_value("handshake_2", handshake_2, 1'b0);
         check_value("data_in", data_in, '0);
      end
      handshake_1 = 1'b0;
      wait_cycles(2);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // pulse monitor sampling on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      cyc++;
      servo_seen = servo;
      for (int ch = 0; ch < nos_channels; ch++) begin
         pulse_ref = expected_pulse(model_config, model_on[ch], ch);
         if (!monitor_on) begin
            width[ch]      = -1;
            last_rise[ch]  = -1;
            rise_count[ch] = 0;
         end else if (servo[ch] && !prev_servo[ch]) begin
            check_value($sformatf("servo[%0d] rise", ch), 1'b1, pulse_ref[32]);
            if (last_rise[ch] >= 0) begin
               check_value($sformatf("servo[%0d] spacing", ch), cyc - last_rise[ch],
                           model_period + 1);
            end
            last_rise[ch] = cyc;
            width[ch]     = 1;
            rise_count[ch]++;
         end else if (servo[ch] && (width[ch] >= 0)) begin
            width[ch]++;
         end else if (!servo[ch] && prev_servo[ch] && (width[ch] >= 0)) begin
            check_value($sformatf("servo[%0d] width", ch), width[ch], pulse_ref[31:0]);
            width[ch] = -1;
         end
      end
      prev_servo = servo;
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int waited;
      reg_address  = '0;
      rw           = 1'b0;
      data_out     = '0;
      handshake_1  = 1'b0;
      monitor_on   = 1'b0;
      cyc          = 0;
      prev_servo   = '0;
      servo_seen   = '0;
      servo_at_ack = '0;
      model_period = '0;
      model_config = '0;
      for (int ch = 0; ch < nos_channels; ch++) begin
         model_on[ch] = '0;
      end
      waited = 0;
      while (reset !== 1'b1) begin
         wait_cycles(1);
         waited++;
         if (waited > 20) begin
            fail_run("reset was never released");
         end
      end

      // reset values with no pulse allowed while everything is zero
      monitor_on = 1'b1;
      read_expect(rc_period_ofs, '0, "period");
      read_expect(rc_config_ofs, '0, "config");
      read_expect(rc_status_ofs, '0, "status");
      for (int ch = 0; ch < nos_channels; ch++) begin
         read_expect(rc_on_time_ofs + addr_t'(ch), '0, $sformatf("on_time[%0d]", ch));
      end
      check_value("servo", servo, '0);

      // random period 40..103 with on-times masked to 1..31 so they stay below it
      rng_state = xorshift(rng_state);
      model_period = (rng_state & 32'h3f) + 32'd40;
      bus_write(rc_base + rc_period_ofs, model_period);
      read_expect(rc_period_ofs, model_period, "period");
      for (int ch = 0; ch < nos_channels; ch++) begin
         rng_state = xorshift(rng_state);
         model_on[ch] = (rng_state & 32'h1f) | 32'h1;
         bus_write(rc_base + rc_on_time_ofs + addr_t'(ch), model_on[ch]);
         read_expect(rc_on_time_ofs + addr_t'(ch), model_on[ch], $sformatf("on_time[%0d]", ch));
      end
      // status ignores writes and still shows idle outputs and no global enable
      rng_state = xorshift(rng_state);
      bus_write(rc_base + rc_status_ofs, rng_state);
      read_expect(rc_status_ofs, '0, "status");

      // all channels running with status sampled at random points in the frame
      apply_config(32'h8000_000f);
      for (int n = 0; n < 4; n++) begin
         rng_state = xorshift(rng_state);
         wait_cycles(rng_state % (model_period + 1) + 1);
         bus_read(rc_base + rc_status_ofs, rd);
         check_value("status[31]", rd[31], 1'b1);
         check_value("status servo bits", rd[nos_channels-1:0], servo_at_ack);
      end
      wait_cycles(5 * (model_period + 1));
      check_pulse_counts();

      // channel 2 disabled and channel 1 with zero on-time
      monitor_on = 1'b0;
      bus_write(rc_base + rc_on_time_ofs + addr_t'(1), '0);
      model_on[1] = '0;
      apply_config(32'h8000_000b);
      wait_cycles(5 * (model_period + 1));
      check_pulse_counts();

      // global enable off so nothing new may start
      apply_config(32'h0000_000b);
      wait_cycles(4 * (model_period + 1));
      check_pulse_counts();
      bus_read(rc_base + rc_status_ofs, rd);
      check_value("status", rd, '0);

      // just past the window and below it
      probe_unmapped(rc_base + rc_window_words);
      probe_unmapped(8'h10);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- tb.f
rtl/rc_servo_pkg.sv
rtl/bus_fsm.sv
rtl/rc_servo_channel.sv
rtl/rc_servo.sv
tests/tb_clock.sv
tests/tb_rc_servo.sv
